// File: bench/pd_sva.sv
// ====================
// Decoder assertions
// ====================
`timescale 1ns/1ps

module pd_sva
	import pd_pkg::*;
(
	input logic                clk_sys,
	input logic                rst,
	input logic                strob1,
	input logic                w_ir,
	input logic [0:IR_WIDTH-1] w,
	input ir_word_t            ir,
	input logic                ewa, ewp, ewe, ewz, ewr, ewm, eww, ewx, ekc
);

	int fail_count = 0;	// Assertion failures so far

	ir_load: assert property (@(posedge clk_sys) disable iff (rst)
		(strob1 && w_ir) |=> (ir == $past(w)))
	else begin
		fail_count++;
		$error("IR did not take the W bus on a qualified strobe");
	end

	ir_clear: assert property (@(posedge clk_sys) rst |=> (ir == '0))
	else begin
		fail_count++;
		$error("IR not cleared by reset");
	end

	ew_onehot: assert property (@(posedge clk_sys)
		$onehot0({ewa, ewp, ewe, ewz, ewr, ewm, eww, ewx, ekc}))
	else begin
		fail_count++;
		$error("Two next-state strobes high together");
	end

endmodule

// File: include/pd_tb_model.svh
// ====================
// Decoder reference model
// ====================
`ifndef PD_TB_MODEL_SVH
`define PD_TB_MODEL_SVH

// One-hot sequencer state, PP in the top bit
typedef struct packed {
	logic pp, wm, wp, ww, wx, wr, wa, wz, we, p4, wamp;
} state_t;

// Next-state strobes in port order
typedef struct packed {
	logic ewa, ewp, ewe, ewz, ewr, ewm, eww, ewx, ekc;
} ew_t;

function automatic logic exp_xi(ir_word_t v, logic q);
	logic [5:0] op;
	op = v.n.opcode;
	if (op < OP_LW)
		return 1'b1;	// Unassigned low opcodes
	if (q && (op == OP_S || (INOU_USER_ILLEGAL && (op == OP_IN || op == OP_OU))))
		return 1'b1;	// Privileged in user mode
	return (op == OP_C) && (v.n.b != 3'd0);
endfunction

// Flag tested by each A value, index 0 is the unconditional form
function automatic logic jump_met(ir_word_t v, logic [0:8] r0);
	logic [0:7] js_flag;
	logic [0:7] j_flag;
	js_flag = {1'b1, r0[R0_L], r0[R0_E], r0[R0_G], r0[R0_V], r0[R0_X], r0[R0_Y], r0[R0_C]};
	j_flag  = {1'b1, r0[R0_L], r0[R0_E], r0[R0_G], r0[R0_Z], r0[R0_M], ~r0[R0_E], 1'b1};
	if (v.n.opcode == OP_JS)
		return js_flag[v.n.a];
	if (v.n.opcode == OP_J)
		return j_flag[v.n.a];
	return 1'b1;
endfunction

function automatic logic exp_nef(ir_word_t v, logic q, p, mc_3, logic [0:8] r0);
	logic md_over;
	md_over = (v.n.opcode == OP_BNG) && (v.n.a == A_MD) && mc_3;	// Premod limit hit
	return exp_xi(v, q) | p | ~jump_met(v, r0) | md_over;
endfunction

// Returns {saryt, ap1, am1, add, sub, or, and, xor}
function automatic logic [7:0] exp_alu(ir_word_t v, state_t s);
	logic add, sub, orl, andl, xorl, inc, dec;
	{add, sub, orl, andl, xorl, inc, dec} = '0;
	case (v.n.opcode)
		OP_AW, OP_AC, OP_AWT: add = s.wamp;
		OP_SW, OP_CW, OP_CWT: sub = s.wamp;
		OP_C:                 sub = s.wamp && (v.n.c == C_NGL);
		OP_OR:                orl = s.wamp || s.wz;
		OP_NR:                andl = s.wamp || s.wz;
		OP_ER, OP_XR:         xorl = s.wamp || s.wz;
		OP_IRB, OP_DRB: begin
			inc = s.wamp && (v.n.opcode == OP_IRB);
			dec = s.wamp && (v.n.opcode == OP_DRB);
			add = s.we;	// Jump target
		end
		default: ;
	endcase
	add = add | s.p4;	// T added in P4
	return {add | sub | inc | dec, inc, dec, add, sub, orl, andl, xorl};
endfunction

function automatic ew_t exp_ew(ir_word_t v, state_t s, logic lk, logic wzi);
	logic [5:0] op;
	logic two_arg, store, inou, byte_op, krb, hlt_sin, mcl_gi;
	ew_t e;
	op      = v.n.opcode;
	two_arg = (op >= OP_LW) && (op <= OP_CB);
	store   = (op == OP_RW) || (op == OP_PW);
	inou    = (op == OP_IN) || (op == OP_OU);
	byte_op = (op == OP_LB) || (op == OP_RB) || (op == OP_CB);
	krb     = (op == OP_IRB) || (op == OP_DRB);
	hlt_sin = (op == OP_S) && (v.n.a == A_HLT || v.n.a == A_SIN);
	mcl_gi  = (op == OP_S) && (v.n.a == A_MCL || v.n.a == A_GI);
	e.ewa = s.pp && two_arg && !store && !inou;
	e.ewp = (s.pp && (op == OP_JS || op == OP_J)) || (s.wa && op == OP_RJ);
	e.ewe = (s.wa && op == OP_LS) || (s.wamp && krb && !wzi);
	e.ewz = s.wamp && (op == OP_IS) && !wzi;	// IS stores only if nonzero
	e.ewr = (s.we && op == OP_LWS) || (s.wr && op == OP_L && lk) || (s.wx && op == OP_L)
		|| (s.wp && byte_op) || (s.wm && inou && !lk);
	e.ewm = s.pp && (inou || mcl_gi);
	e.eww = (s.pp && store) || (s.wa && op == OP_RI) || (s.we && op == OP_RWS)
		|| (s.wx && op == OP_G) || (s.ww && op == OP_G && lk);
	e.ewx = (s.pp && (hlt_sin || op == OP_L || op == OP_G)) || (s.wm && inou && lk);
	e.ekc = (s.wamp && two_arg && !e.ewz) || (s.wamp && krb && wzi)
		|| (s.wr && op == OP_L && !lk) || (s.wx && hlt_sin)
		|| (s.ww && !(op == OP_G && lk)) || (s.wp && !byte_op) || (s.wm && !inou);
	return e;
endfunction

`endif

// File: bench/pd_tb.sv
// ====================
// P-D decoder testbench
// ====================
`timescale 1ns/1ps

module pd_tb
	import pd_pkg::*;
();

	localparam int NUM_TESTS  = 4000;	// Random cycles after reset
	localparam int CLK_PERIOD = 4;

	`include "pd_tb_model.svh"

	logic                clk_sys = 1'b0;
	logic                rst, strob1, w_ir, q, mc_3, p, lk, wzi;
	logic [0:IR_WIDTH-1] w;
	logic [0:8]          r0;
	state_t              st;
	ir_word_t            ir;
	ir_word_t            exp_ir;	// Shadow IR
	logic                xi, nef, saryt, ap1, am1;
	logic                alu_add, alu_sub, alu_or, alu_and, alu_xor;
	ew_t                 ew;
	logic [31:0]         rng_state = 32'd80;
	string ew_names [9] = '{"ewa", "ewp", "ewe", "ewz", "ewr", "ewm", "eww", "ewx", "ekc"};

	pd u_dut (
		.clk_sys, .rst, .strob1, .w_ir, .w, .q, .mc_3, .p, .r0,
		.st_wamp(st.wamp), .st_p4(st.p4), .st_we(st.we), .st_wz(st.wz), .st_wa(st.wa),
		.st_wr(st.wr), .st_wx(st.wx), .st_ww(st.ww), .st_wp(st.wp), .st_wm(st.wm),
		.st_pp(st.pp), .lk, .wzi, .ir, .xi, .nef, .saryt, .ap1, .am1,
		.alu_add, .alu_sub, .alu_or, .alu_and, .alu_xor,
		.ewa(ew.ewa), .ewp(ew.ewp), .ewe(ew.ewe), .ewz(ew.ewz), .ewr(ew.ewr),
		.ewm(ew.ewm), .eww(ew.eww), .ewx(ew.ewx), .ekc(ew.ekc)
	);

	bind pd pd_sva u_sva (.*);

	initial begin
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#((NUM_TESTS + 10) * CLK_PERIOD + 100);	// Test length plus margin
		$display("Test loop did not finish before the watchdog time ran out");
		$display("Something failed");
		$fatal(1, "Watchdog expired");
	end

	function automatic logic [15:0] next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state[31:16];	// Upper bits have the longer period
	endfunction

	task automatic stop_on_error();
		$display("Something failed");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_word(string name, ir_word_t got, ir_word_t exp);
		if (got !== exp) begin
			$display("FAIL at %0t ns: %s got %h expected %h", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("FAIL at %0t ns: %s got %b expected %b", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_sel(string name, logic [7:0] got, logic [7:0] exp);
		if (got !== exp) begin
			$display("FAIL at %0t ns: %s got %b expected %b", $time, name, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_outputs();
		ew_t ew_exp;
		ew_exp = exp_ew(exp_ir, st, lk, wzi);
		check_word("ir", ir, exp_ir);
		check_bit("xi", xi, exp_xi(exp_ir, q));
		check_bit("nef", nef, exp_nef(exp_ir, q, p, mc_3, r0));
		check_sel("saryt/ap1/am1/alu_sel",
			{saryt, ap1, am1, alu_add, alu_sub, alu_or, alu_and, alu_xor}, exp_alu(exp_ir, st));
		for (int k = 0; k < 9; k++)
			check_bit(ew_names[k], ew[8 - k], ew_exp[8 - k]);
		if (!$onehot0(ew)) begin
			$display("More than one next-state strobe is high at %0t ns", $time);
			stop_on_error();
		end
		if (u_dut.u_sva.fail_count != 0) begin
			$display("A pd_sva assertion failed before %0t ns", $time);
			stop_on_error();
		end
	endtask

	task automatic drive_inputs(int n);
		logic [15:0] r1;
		logic [15:0] r2;
		w  = next_rand();
		r1 = next_rand();
		r2 = next_rand();
		rst    = (n % 500 == 499);	// Occasional reset mid-run
		strob1 = r1[0];
		w_ir   = r1[1];
		q      = r1[2];
		mc_3   = r1[3];
		p      = (r1[6:4] == 3'd0);	// Rare skip
		lk     = r1[7];
		wzi    = r1[8];
		r0     = r2[8:0];
		st     = (r2[15:12] < 4'd11) ? state_t'(11'd1 << r2[15:12]) : '0;
	endtask

	initial begin
		rst = 1'b1;
		{strob1, w_ir, q, mc_3, p, lk, wzi} = '0;
		w      = '0;
		r0     = '0;
		st     = '0;
		exp_ir = '0;
		repeat (4) @(negedge clk_sys);
		rst = 1'b0;
		for (int n = 0; n < NUM_TESTS; n++) begin
			check_outputs();	// Inputs held since last falling edge
			drive_inputs(n);
			@(posedge clk_sys);
			if (rst)
				exp_ir = '0;
			else if (strob1 && w_ir)
				exp_ir = w;
			@(negedge clk_sys);
		end
		check_outputs();
		if (u_dut.u_sva.fail_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("%0d assertion failures", u_dut.u_sva.fail_count);
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: design/pd.sv
// ====================
// P-D decoder top
// ====================
`timescale 1ns/1ps

module pd
	import pd_pkg::*;
(
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                strob1,
	input  logic                w_ir,
	input  logic [0:IR_WIDTH-1] w,
	input  logic                q,
	input  logic                mc_3,
	input  logic                p,
	input  logic [0:8]          r0,
	input  logic                st_wamp, st_p4, st_we, st_wz, st_wa, st_wr,
	input  logic                st_wx, st_ww, st_wp, st_wm, st_pp,
	input  logic                lk,
	input  logic                wzi,
	output ir_word_t            ir,
	output logic                xi, nef,
	output logic                saryt, ap1, am1,
	output logic                alu_add, alu_sub, alu_or, alu_and, alu_xor,
	output logic                ewa, ewp, ewe, ewz, ewr, ewm, eww, ewx, ekc
);

	logic is, rw, pw, ri, rj, ls, lws, rws, irb, drb, lb, rb, cb;
	logic aw, ac, awt, sw, ngl, cw, cwt, orr, nr, er, xr;
	logic inou, grp_s, grp_bn, grp_c, js, j, l, g, hlt, mcl, sin, gi;

	pd_ir u_ir (.clk_sys, .rst, .strob1, .w_ir, .w, .ir);

	// Strobes not used by the control blocks stay internal to the decoder
	pd_opdec u_opdec (
		.ir, .lw(), .tw(), .ls, .ri, .rw, .pw, .rj, .is,
		.bb(), .bm(), .bs(), .bc(), .bn(), .ou(), .in(), .pufa(),
		.aw, .ac, .sw, .cw, .orr, .om(), .nr, .nm(),
		.er, .em(), .xr, .xm(), .cl(), .lb, .rb, .cb,
		.awt, .trb(), .irb, .drb, .cwt, .lwt(), .lws, .rws,
		.js, .ka2(), .grp_c, .grp_s, .j, .l, .g, .grp_bn,
		.hlt, .mcl, .sin, .gi, .lip(),
		.ngl, .rpc(), .lpc(), .shc(), .ka1(), .inou
	);

	pd_legal u_legal (.ir, .q, .mc_3, .p, .r0, .inou, .grp_s, .grp_bn, .grp_c, .js, .j, .xi, .nef);

	pd_alu_ctl u_alu (
		.st_wamp, .st_p4, .st_we, .st_wz,
		.aw, .ac, .awt, .sw, .ngl, .cw, .cwt, .orr, .nr, .er, .xr, .irb, .drb,
		.saryt, .ap1, .am1, .alu_add, .alu_sub, .alu_or, .alu_and, .alu_xor
	);

	pd_seq u_seq (
		.ir, .st_pp, .st_wamp, .st_we, .st_wa, .st_wr, .st_wx, .st_ww, .st_wp, .st_wm,
		.lk, .wzi,
		.is, .rw, .pw, .ri, .rj, .ls, .lws, .rws, .irb, .drb, .lb, .rb, .cb, .inou,
		.js, .j, .l, .g, .hlt, .mcl, .sin, .gi,
		.ewa, .ewp, .ewe, .ewz, .ewr, .ewm, .eww, .ewx, .ekc
	);

endmodule

// File: design/pd_alu_ctl.sv
// ====================
// ALU control
// ====================
`timescale 1ns/1ps

module pd_alu_ctl (
	input  logic st_wamp,	// W& execute state
	input  logic st_p4,	// Short argument add
	input  logic st_we,
	input  logic st_wz,	// Memory write-back
	input  logic aw,
	input  logic ac,
	input  logic awt,
	input  logic sw,
	input  logic ngl,
	input  logic cw,
	input  logic cwt,
	input  logic orr,
	input  logic nr,
	input  logic er,
	input  logic xr,
	input  logic irb,
	input  logic drb,
	output logic saryt,	// Arithmetic, not logic
	output logic ap1,	// A plus 1
	output logic am1,	// A minus 1
	output logic alu_add,
	output logic alu_sub,
	output logic alu_or,
	output logic alu_and,
	output logic alu_xor
);

	logic add_op;
	logic sub_op;	// Compare and negate also subtract
	logic logic_st;	// States where logic ops pass the ALU

	assign add_op   = aw | ac | awt;
	assign sub_op   = sw | ngl | cw | cwt;
	assign logic_st = st_wamp | st_wz;

	// P4 adds T, WE forms the IRB/DRB jump target
	assign alu_add = (st_wamp & add_op) | st_p4 | (st_we & (irb | drb));
	assign alu_sub = st_wamp & sub_op;
	assign alu_or  = logic_st & orr;
	assign alu_and = logic_st & nr;
	assign alu_xor = logic_st & (er | xr);

	assign ap1 = st_wamp & irb;
	assign am1 = st_wamp & drb;

	assign saryt = alu_add | alu_sub | ap1 | am1;

endmodule

// File: design/pd_ir.sv
// ====================
// Instruction register
// ====================
`timescale 1ns/1ps

module pd_ir
	import pd_pkg::*;
(
	input  logic                clk_sys,
	input  logic                rst,
	input  logic                strob1,	// Bus strobe
	input  logic                w_ir,	// W to IR request
	input  logic [0:IR_WIDTH-1] w,	// W bus, bit 0 is MSB
	output ir_word_t            ir
);

	logic load;	// Qualified write

	assign load = strob1 & w_ir;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ir <= '0;	// Opcode 0 decodes as illegal
		end else if (load) begin
			ir <= w;	// Plain overwrite, no hold-off
		end
	end

endmodule

// File: design/pd_legal.sv
// ====================
// Illegal / no-effect
// ====================
`timescale 1ns/1ps

module pd_legal
	import pd_pkg::*;
(
	input  ir_word_t   ir,
	input  logic       q,	// System flag, user mode
	input  logic       mc_3,	// Third premodification in a row
	input  logic       p,	// Skip flag
	input  logic [0:8] r0,	// R0 flags, Z first
	input  logic       inou,
	input  logic       grp_s,
	input  logic       grp_bn,
	input  logic       grp_c,
	input  logic       js,
	input  logic       j,
	output logic       xi,
	output logic       nef
);

	logic low_op;	// 000-017 unassigned
	logic user_trap;
	logic c_bad;	// C group wants B = 0
	logic jcond;	// Jump condition met
	logic md_over;	// MD beyond premod limit

	assign low_op    = (ir.n.opcode[5:4] == 2'b00);
	assign user_trap = q & ((INOU_USER_ILLEGAL & inou) | grp_s);
	assign c_bad     = grp_c & (ir.n.b != 3'd0);
	assign md_over   = grp_bn & (ir.n.a == A_MD) & mc_3;

	// A field selects the tested R0 flag
	always_comb begin
		jcond = 1'b1;	// UJ, UJS, LJ
		if (js) begin
			case (ir.n.a)
				A_JL:    jcond = r0[R0_L];
				A_JE:    jcond = r0[R0_E];
				A_JG:    jcond = r0[R0_G];
				A_JVS:   jcond = r0[R0_V];
				A_JXS:   jcond = r0[R0_X];
				A_JYS:   jcond = r0[R0_Y];
				A_JCS:   jcond = r0[R0_C];
				default: jcond = 1'b1;
			endcase
		end else if (j) begin
			case (ir.n.a)
				A_JL:    jcond = r0[R0_L];
				A_JE:    jcond = r0[R0_E];
				A_JG:    jcond = r0[R0_G];
				A_JZ:    jcond = r0[R0_Z];
				A_JM:    jcond = r0[R0_M];
				A_JN:    jcond = ~r0[R0_E];	// Jump if not equal, E must be clear
				default: jcond = 1'b1;
			endcase
		end
	end

	assign xi  = low_op | user_trap | c_bad;
	assign nef = xi | p | ~jcond | md_over;	// Skipped or failed condition

endmodule

// File: design/pd_opdec.sv
// ====================
// Opcode decoder
// ====================
`timescale 1ns/1ps

module pd_opdec
	import pd_pkg::*;
(
	input  ir_word_t ir,
	// 020-037
	output logic lw, tw, ls, ri, rw, pw, rj, is,
	output logic bb, bm, bs, bc, bn, ou, in, pufa,
	// 040-057
	output logic aw, ac, sw, cw, orr, om, nr, nm,
	output logic er, em, xr, xm, cl, lb, rb, cb,
	// 060-067
	output logic awt, trb, irb, drb, cwt, lwt, lws, rws,
	// 070-077
	output logic js, ka2, grp_c, grp_s, j, l, g, grp_bn,
	// S and C group members
	output logic hlt, mcl, sin, gi, lip,
	output logic ngl, rpc, lpc, shc,
	output logic ka1, inou
);

	logic [5:0]  op;
	logic [15:0] dec;	// One-hot of low four opcode bits
	logic        quarter_1;	// 020-037
	logic        quarter_2;	// 040-057
	logic        quarter_3;	// 060-077

	assign op = ir.n.opcode;
	assign dec = 16'd1 << op[3:0];
	assign quarter_1 = (op[5:4] == OP_LW[5:4]);
	assign quarter_2 = (op[5:4] == OP_AW[5:4]);
	assign quarter_3 = (op[5:4] == OP_AWT[5:4]);

	assign lw   = quarter_1 & dec[OP_LW[3:0]];
	assign tw   = quarter_1 & dec[OP_TW[3:0]];
	assign ls   = quarter_1 & dec[OP_LS[3:0]];
	assign ri   = quarter_1 & dec[OP_RI[3:0]];
	assign rw   = quarter_1 & dec[OP_RW[3:0]];
	assign pw   = quarter_1 & dec[OP_PW[3:0]];
	assign rj   = quarter_1 & dec[OP_RJ[3:0]];
	assign is   = quarter_1 & dec[OP_IS[3:0]];
	assign bb   = quarter_1 & dec[OP_BB[3:0]];
	assign bm   = quarter_1 & dec[OP_BM[3:0]];
	assign bs   = quarter_1 & dec[OP_BS[3:0]];
	assign bc   = quarter_1 & dec[OP_BC[3:0]];
	assign bn   = quarter_1 & dec[OP_BN[3:0]];
	assign ou   = quarter_1 & dec[OP_OU[3:0]];
	assign in   = quarter_1 & dec[OP_IN[3:0]];
	assign pufa = quarter_1 & dec[OP_PUFA[3:0]];	// Wide and FP arithmetic

	assign aw  = quarter_2 & dec[OP_AW[3:0]];
	assign ac  = quarter_2 & dec[OP_AC[3:0]];
	assign sw  = quarter_2 & dec[OP_SW[3:0]];
	assign cw  = quarter_2 & dec[OP_CW[3:0]];
	assign orr = quarter_2 & dec[OP_OR[3:0]];
	assign om  = quarter_2 & dec[OP_OM[3:0]];
	assign nr  = quarter_2 & dec[OP_NR[3:0]];
	assign nm  = quarter_2 & dec[OP_NM[3:0]];
	assign er  = quarter_2 & dec[OP_ER[3:0]];
	assign em  = quarter_2 & dec[OP_EM[3:0]];
	assign xr  = quarter_2 & dec[OP_XR[3:0]];
	assign xm  = quarter_2 & dec[OP_XM[3:0]];
	assign cl  = quarter_2 & dec[OP_CL[3:0]];
	assign lb  = quarter_2 & dec[OP_LB[3:0]];
	assign rb  = quarter_2 & dec[OP_RB[3:0]];
	assign cb  = quarter_2 & dec[OP_CB[3:0]];

	assign awt = quarter_3 & dec[OP_AWT[3:0]];
	assign trb = quarter_3 & dec[OP_TRB[3:0]];
	assign irb = quarter_3 & dec[OP_IRB[3:0]];
	assign drb = quarter_3 & dec[OP_DRB[3:0]];
	assign cwt = quarter_3 & dec[OP_CWT[3:0]];
	assign lwt = quarter_3 & dec[OP_LWT[3:0]];
	assign lws = quarter_3 & dec[OP_LWS[3:0]];
	assign rws = quarter_3 & dec[OP_RWS[3:0]];

	assign js     = quarter_3 & dec[OP_JS[3:0]];
	assign ka2    = quarter_3 & dec[OP_KA2[3:0]];
	assign grp_c  = quarter_3 & dec[OP_C[3:0]];
	assign grp_s  = quarter_3 & dec[OP_S[3:0]];
	assign j      = quarter_3 & dec[OP_J[3:0]];
	assign l      = quarter_3 & dec[OP_L[3:0]];
	assign g      = quarter_3 & dec[OP_G[3:0]];
	assign grp_bn = quarter_3 & dec[OP_BNG[3:0]];

	// S group, member picked by A field
	assign hlt = grp_s & (ir.n.a == A_HLT);
	assign mcl = grp_s & (ir.n.a == A_MCL);
	assign sin = grp_s & (ir.n.a == A_SIN);	// SIU/SIL/SIT/CIT
	assign gi  = grp_s & (ir.n.a == A_GI);
	assign lip = grp_s & (ir.n.a == A_LIP);

	// C group, member picked by C field
	assign ngl = grp_c & (ir.n.c == C_NGL);
	assign rpc = grp_c & (ir.n.c == C_RPC);
	assign lpc = grp_c & (ir.n.c == C_LPC);
	assign shc = grp_c & (ir.n.c == C_SHC);

	// KA1 words carry T in place of B and C
	assign ka1  = (ir.s.opcode[5:3] == OP_AWT[5:3]);
	assign inou = in | ou;

endmodule

// File: design/pd_pkg.sv
// ====================
// P-D decoder defs
// ====================
package pd_pkg;

	localparam int IR_WIDTH = 16;	// Instruction word width

	// Two-argument view, used by everything but KA1
	typedef struct packed {
		logic [5:0] opcode;
		logic       d;	// Indirect flag
		logic [2:0] a;	// Register A or group member
		logic [2:0] b;	// Modifier register
		logic [2:0] c;	// Argument register, 0 means next word
	} ir_norm_t;

	// Short-argument view, KA1 group
	typedef struct packed {
		logic [5:0] opcode;
		logic       sign;	// Sign of T
		logic [2:0] a;
		logic [5:0] t;	// Short argument magnitude
	} ir_short_t;

	typedef union packed {
		ir_norm_t  n;
		ir_short_t s;
	} ir_word_t;

	localparam logic [5:0]
		OP_LW   = 6'o20, OP_TW  = 6'o21, OP_LS  = 6'o22, OP_RI   = 6'o23,
		OP_RW   = 6'o24, OP_PW  = 6'o25, OP_RJ  = 6'o26, OP_IS   = 6'o27,
		OP_BB   = 6'o30, OP_BM  = 6'o31, OP_BS  = 6'o32, OP_BC   = 6'o33,
		OP_BN   = 6'o34, OP_OU  = 6'o35, OP_IN  = 6'o36, OP_PUFA = 6'o37,
		OP_AW   = 6'o40, OP_AC  = 6'o41, OP_SW  = 6'o42, OP_CW   = 6'o43,
		OP_OR   = 6'o44, OP_OM  = 6'o45, OP_NR  = 6'o46, OP_NM   = 6'o47,
		OP_ER   = 6'o50, OP_EM  = 6'o51, OP_XR  = 6'o52, OP_XM   = 6'o53,
		OP_CL   = 6'o54, OP_LB  = 6'o55, OP_RB  = 6'o56, OP_CB   = 6'o57,
		OP_AWT  = 6'o60, OP_TRB = 6'o61, OP_IRB = 6'o62, OP_DRB  = 6'o63,
		OP_CWT  = 6'o64, OP_LWT = 6'o65, OP_LWS = 6'o66, OP_RWS  = 6'o67,
		OP_JS   = 6'o70, OP_KA2 = 6'o71, OP_C   = 6'o72, OP_S    = 6'o73,
		OP_J    = 6'o74, OP_L   = 6'o75, OP_G   = 6'o76, OP_BNG  = 6'o77;

	// S group members, by A field
	localparam logic [2:0]
		A_HLT = 3'd0, A_MCL = 3'd1, A_SIN = 3'd2, A_GI = 3'd3, A_LIP = 3'd4;

	// Jump conditions, J group and JS group share L/E/G
	localparam logic [2:0]
		A_JL  = 3'd1, A_JE  = 3'd2, A_JG  = 3'd3,
		A_JZ  = 3'd4, A_JM  = 3'd5, A_JN  = 3'd6,
		A_JVS = 3'd4, A_JXS = 3'd5, A_JYS = 3'd6, A_JCS = 3'd7;

	localparam logic [2:0] A_MD = 3'd5;	// B/N group premodifier

	// C group members, by C field
	localparam logic [2:0]
		C_NGL = 3'd3, C_SHC = 3'd5, C_RPC = 3'd6, C_LPC = 3'd7;

	// R0 flag positions, bit 0 is leftmost
	localparam int
		R0_Z = 0, R0_M = 1, R0_V = 2, R0_C = 3, R0_L = 4,
		R0_E = 5, R0_G = 6, R0_Y = 7, R0_X = 8;

	localparam logic INOU_USER_ILLEGAL = 1'b1;	// IN/OU trap in user mode

endpackage

// File: design/pd_seq.sv
// ====================
// Next-state strobes
// ====================
`timescale 1ns/1ps

module pd_seq
	import pd_pkg::*;
(
	input  ir_word_t ir,
	input  logic st_pp,	// Fetch done, pick first state
	input  logic st_wamp,
	input  logic st_we,
	input  logic st_wa,
	input  logic st_wr,
	input  logic st_wx,
	input  logic st_ww,
	input  logic st_wp,
	input  logic st_wm,
	input  logic lk,	// Loop count not exhausted
	input  logic wzi,	// Result zero
	input  logic is, rw, pw, ri, rj, ls, lws, rws,
	input  logic irb, drb, lb, rb, cb, inou,
	input  logic js, j, l, g, hlt, mcl, sin, gi,
	output logic ewa,
	output logic ewp,
	output logic ewe,
	output logic ewz,
	output logic ewr,
	output logic ewm,
	output logic eww,
	output logic ewx,
	output logic ekc	// End of cycle
);

	logic two_arg;	// 020-057
	logic store;
	logic byte_op;	// LB, RB, CB
	logic krb;	// IRB or DRB
	logic is_wb;	// IS has to write memory

	assign two_arg = (ir.n.opcode[5:4] == OP_LW[5:4]) || (ir.n.opcode[5:4] == OP_AW[5:4]);
	assign store   = rw | pw;
	assign byte_op = lb | rb | cb;
	assign krb     = irb | drb;
	assign is_wb   = is & ~wzi;

	assign ewa = st_pp & two_arg & ~store & ~inou;	// Fetch argument
	assign ewp = (st_pp & (js | j)) | (st_wa & rj);
	assign ewe = (st_wa & ls) | (st_wamp & krb & ~wzi);	// Nonzero counter jumps
	assign ewz = st_wamp & is_wb;
	assign ewm = st_pp & (inou | mcl | gi);

	assign ewr = (st_we & lws)
		| (st_wr & l & lk)	// Next register of L group
		| (st_wx & l)
		| (st_wp & byte_op)
		| (st_wm & inou & ~lk);

	assign eww = (st_pp & store)
		| (st_wa & ri)
		| (st_we & rws)
		| (st_wx & g)
		| (st_ww & g & lk);

	assign ewx = (st_pp & (hlt | sin | l | g)) | (st_wm & inou & lk);

	assign ekc = (st_wamp & two_arg & ~is_wb)
		| (st_wamp & krb & wzi)
		| (st_wr & l & ~lk)
		| (st_wx & (hlt | sin))
		| (st_ww & ~(g & lk))
		| (st_wp & ~byte_op)
		| (st_wm & ~inou);

endmodule

// File: list.f
+incdir+include
design/pd_pkg.sv
design/pd_ir.sv
design/pd_opdec.sv
design/pd_legal.sv
design/pd_alu_ctl.sv
design/pd_seq.sv
design/pd.sv
bench/pd_sva.sv
bench/pd_tb.sv
